//--- verilog/frontend_settings.svh
// Build-time settings of the in-order front end
// Include wherever widths, depths or the reset address are needed
`ifndef FRONTEND_SETTINGS_SVH
`define FRONTEND_SETTINGS_SVH

// Instructions per fetch block and decode lanes
`define FETCH_WIDTH 2
`define DECODE_WIDTH 2

// Entries in the fetch address queue and the instruction buffer
`define FAQ_DEPTH 4
`define IBUF_DEPTH 8

// Virtual address width
`define VADDR_WIDTH 32

// First fetch address, block aligned
`define RESET_PC 32'h0000_1000

`endif

//--- verilog/frontend_pkg.sv
// Shared types of the front end: opcode and unit encodings plus the
// structs passed between fetch, instruction buffer and decode
`include "frontend_settings.svh"

package frontend_pkg;

  // Opcode from instruction bits 31:28, codes 8 to 15 are illegal
  typedef enum logic [3:0] {
    OP_ADD    = 4'd0,
    OP_SUB    = 4'd1,
    OP_AND    = 4'd2,
    OP_OR     = 4'd3,
    OP_LOAD   = 4'd4,
    OP_STORE  = 4'd5,
    OP_BRANCH = 4'd6,
    OP_NOP    = 4'd7
  } op_e;

  typedef enum logic [1:0] {
    UNIT_ALU  = 2'd0,
    UNIT_MEM  = 2'd1,
    UNIT_MISC = 2'd2
  } exec_unit_e;

  // Block read towards instruction memory
  typedef struct packed {
    logic                    valid;
    logic [`VADDR_WIDTH-1:0] addr;
  } imem_req_t;

  // Returned block, word 0 sits at the block address
  typedef struct packed {
    logic                          valid;
    logic [`FETCH_WIDTH-1:0][31:0] data;
  } imem_rsp_t;

  typedef struct packed {
    logic [31:0]             inst;
    logic [`VADDR_WIDTH-1:0] pc;
  } ibuf_entry_t;

  typedef struct packed {
    logic                    valid;
    logic [`VADDR_WIDTH-1:0] pc;
    op_e                     op;
    exec_unit_e              unit;
    logic                    illegal;
    logic [4:0]              rd;
    logic [4:0]              rs0;
    logic [4:0]              rs1;
    logic [31:0]             imm;
  } decoded_inst_t;

endpackage

//--- verilog/fetch_address_queue.sv
// Generates sequential fetch-block addresses and buffers them for the
// fetch unit. A redirect empties the queue and restarts at the target
`include "frontend_settings.svh"

module fetch_address_queue (
  input  logic                    clk,
  input  logic                    rst_i,
  input  logic                    redirect_i,
  input  logic [31:0]             redirect_pc_i,
  input  logic                    pop_ready_i,
  output logic                    pop_valid_o,
  output logic [`VADDR_WIDTH-1:0] pop_addr_o
);

  localparam int PTR_W = $clog2(`FAQ_DEPTH);
  localparam int CNT_W = $clog2(`FAQ_DEPTH + 1);
  localparam logic [`VADDR_WIDTH-1:0] BLOCK_BYTES = `VADDR_WIDTH'(`FETCH_WIDTH * 4);

  logic [`VADDR_WIDTH-1:0] next_pc;
  logic [`VADDR_WIDTH-1:0] fifo_mem [`FAQ_DEPTH];
  logic [PTR_W-1:0]        wr_ptr;
  logic [PTR_W-1:0]        rd_ptr;
  logic [CNT_W-1:0]        count;
  logic                    push;
  logic                    pop;

  // Always sequential, so the generator pushes whenever there is room
  assign push        = (count != CNT_W'(`FAQ_DEPTH));
  assign pop_valid_o = (count != '0);
  assign pop         = pop_valid_o && pop_ready_i;
  assign pop_addr_o  = fifo_mem[rd_ptr];

  // ==========================================================================
  // Next-block register and queue pointers
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (rst_i) begin
      next_pc <= `RESET_PC;
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
    end else if (redirect_i) begin
      next_pc <= redirect_pc_i;
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
    end else begin
      if (push) begin
        next_pc <= next_pc + BLOCK_BYTES;
        wr_ptr  <= wr_ptr + PTR_W'(1);
      end
      if (pop) begin
        rd_ptr <= rd_ptr + PTR_W'(1);
      end
      count <= count + CNT_W'(push) - CNT_W'(pop);
    end
  end

  // Address storage
  always_ff @(posedge clk) begin
    if (push) begin
      fifo_mem[wr_ptr] <= next_pc;
    end
  end

endmodule

//--- verilog/instruction_fetch_unit.sv
// Pops block addresses, reads the blocks from instruction memory and
// writes each returned block with its addresses into the buffer
`include "frontend_settings.svh"

module instruction_fetch_unit (
  input  logic                                         clk,
  input  logic                                         rst_i,
  input  logic                                         redirect_i,
  input  logic                                         faq_valid_i,
  input  logic [`VADDR_WIDTH-1:0]                      faq_addr_i,
  output logic                                         faq_ready_o,
  output frontend_pkg::imem_req_t                      imem_req_o,
  input  frontend_pkg::imem_rsp_t                      imem_rsp_i,
  input  logic                                         ibuf_wr_ready_i,
  output logic                                         ibuf_wr_valid_o,
  output frontend_pkg::ibuf_entry_t [`FETCH_WIDTH-1:0] ibuf_wr_data_o
);

  logic                    pending;
  logic                    issue;
  logic [`VADDR_WIDTH-1:0] req_addr;

  // One block in flight, and only with room for the whole block
  assign faq_ready_o = ibuf_wr_ready_i && !pending;
  assign issue       = faq_valid_i && faq_ready_o;

  always_comb begin
    imem_req_o.valid = issue;
    imem_req_o.addr  = faq_addr_i;
  end

  // Cleared by redirect so the response still due is dropped
  always_ff @(posedge clk) begin
    if (rst_i || redirect_i) begin
      pending <= 1'b0;
    end else begin
      pending <= issue;
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      req_addr <= faq_addr_i;
    end
  end

  // ==========================================================================
  // Response to buffer, one write pulse per block
  // ==========================================================================
  assign ibuf_wr_valid_o = pending && imem_rsp_i.valid;

  always_comb begin
    for (int i = 0; i < `FETCH_WIDTH; i++) begin
      ibuf_wr_data_o[i].inst = imem_rsp_i.data[i];
      // Word i of the block sits 4 bytes per lane above the base
      ibuf_wr_data_o[i].pc   = req_addr + `VADDR_WIDTH'(4 * i);
    end
  end

endmodule

//--- verilog/instruction_buffer.sv
// Circular instruction buffer, a full fetch block in per write and the
// oldest DECODE_WIDTH entries out per read, in program order
`include "frontend_settings.svh"

module instruction_buffer (
  input  logic                                          clk,
  input  logic                                          rst_i,
  input  logic                                          flush_i,
  input  logic                                          wr_valid_i,
  input  frontend_pkg::ibuf_entry_t [`FETCH_WIDTH-1:0]  wr_data_i,
  output logic                                          wr_ready_o,
  output logic [`DECODE_WIDTH-1:0]                      rd_valid_o,
  output frontend_pkg::ibuf_entry_t [`DECODE_WIDTH-1:0] rd_data_o,
  input  logic                                          rd_ready_i
);

  import frontend_pkg::*;

  localparam int PTR_W = $clog2(`IBUF_DEPTH);
  localparam int CNT_W = $clog2(`IBUF_DEPTH + 1);

  ibuf_entry_t      mem [`IBUF_DEPTH];
  logic [PTR_W-1:0] head;
  logic [PTR_W-1:0] tail;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] wr_num;
  logic [CNT_W-1:0] rd_num;

  // Room for a whole block
  assign wr_ready_o = (CNT_W'(`IBUF_DEPTH) - count) >= CNT_W'(`FETCH_WIDTH);
  assign wr_num     = wr_valid_i ? CNT_W'(`FETCH_WIDTH) : '0;

  // ==========================================================================
  // Read side
  // ==========================================================================
  always_comb begin
    rd_num = '0;
    for (int i = 0; i < `DECODE_WIDTH; i++) begin
      rd_valid_o[i] = count > CNT_W'(i);
      rd_data_o[i]  = mem[head + PTR_W'(i)];
      // All valid lanes retire together
      if (rd_ready_i && rd_valid_o[i]) begin
        rd_num = rd_num + CNT_W'(1);
      end
    end
  end

  // Pointers and fill level
  always_ff @(posedge clk) begin
    if (rst_i || flush_i) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (wr_valid_i) begin
        tail <= tail + PTR_W'(`FETCH_WIDTH);
      end
      head  <= head + PTR_W'(rd_num);
      count <= count + wr_num - rd_num;
    end
  end

  // ==========================================================================
  // Entry storage
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (wr_valid_i) begin
      for (int i = 0; i < `FETCH_WIDTH; i++) begin
        mem[tail + PTR_W'(i)] <= wr_data_i[i];
      end
    end
  end

endmodule

//--- verilog/decoder.sv
// Combinational decode of one instruction word for a single decode lane
`include "frontend_settings.svh"

module decoder (
  input  logic                        valid_i,
  input  logic [31:0]                 inst_i,
  input  logic [`VADDR_WIDTH-1:0]     pc_i,
  output frontend_pkg::decoded_inst_t dec_o
);

  import frontend_pkg::*;

  logic [3:0] opcode;
  logic       illegal;
  op_e        op;
  exec_unit_e unit;

  assign opcode  = inst_i[31:28];
  assign illegal = opcode[3];

  // Illegal codes travel on as a NOP with the flag set
  always_comb begin
    if (illegal) begin
      op = OP_NOP;
    end else begin
      op = op_e'(opcode);
    end
    case (op)
      OP_ADD, OP_SUB, OP_AND, OP_OR: unit = UNIT_ALU;
      OP_LOAD, OP_STORE:             unit = UNIT_MEM;
      default:                       unit = UNIT_MISC;
    endcase
  end

  always_comb begin
    dec_o.valid   = valid_i;
    dec_o.pc      = pc_i;
    dec_o.op      = op;
    dec_o.unit    = unit;
    dec_o.illegal = illegal;
    // Register fields
    dec_o.rd      = inst_i[27:23];
    dec_o.rs0     = inst_i[22:18];
    dec_o.rs1     = inst_i[17:13];
    dec_o.imm     = {{19{inst_i[12]}}, inst_i[12:0]};
  end

endmodule

//--- verilog/frontend_pipeline.sv
// Top of the front end: address queue, fetch unit, instruction buffer and
// one decoder per lane. Decoded lanes leave at dec_o under dec_ready_i
`include "frontend_settings.svh"

module frontend_pipeline (
  input  logic                                            clk,
  input  logic                                            rst_i,
  input  logic                                            redirect_i,
  input  logic [31:0]                                     redirect_pc_i,
  output frontend_pkg::imem_req_t                         imem_req_o,
  input  frontend_pkg::imem_rsp_t                         imem_rsp_i,
  output frontend_pkg::decoded_inst_t [`DECODE_WIDTH-1:0] dec_o,
  input  logic                                            dec_ready_i
);

  import frontend_pkg::*;

  logic                            faq_valid;
  logic                            faq_ready;
  logic [`VADDR_WIDTH-1:0]         faq_addr;
  logic                            ibuf_wr_valid;
  logic                            ibuf_wr_ready;
  ibuf_entry_t [`FETCH_WIDTH-1:0]  ibuf_wr_data;
  logic [`DECODE_WIDTH-1:0]        ibuf_rd_valid;
  ibuf_entry_t [`DECODE_WIDTH-1:0] ibuf_rd_data;

  fetch_address_queue u_faq (
    .clk           (clk),
    .rst_i         (rst_i),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .pop_ready_i   (faq_ready),
    .pop_valid_o   (faq_valid),
    .pop_addr_o    (faq_addr)
  );

  instruction_fetch_unit u_ifu (
    .clk             (clk),
    .rst_i           (rst_i),
    .redirect_i      (redirect_i),
    .faq_valid_i     (faq_valid),
    .faq_addr_i      (faq_addr),
    .faq_ready_o     (faq_ready),
    .imem_req_o      (imem_req_o),
    .imem_rsp_i      (imem_rsp_i),
    .ibuf_wr_ready_i (ibuf_wr_ready),
    .ibuf_wr_valid_o (ibuf_wr_valid),
    .ibuf_wr_data_o  (ibuf_wr_data)
  );

  // Redirect empties the buffer on the same edge
  instruction_buffer u_ibuf (
    .clk        (clk),
    .rst_i      (rst_i),
    .flush_i    (redirect_i),
    .wr_valid_i (ibuf_wr_valid),
    .wr_data_i  (ibuf_wr_data),
    .wr_ready_o (ibuf_wr_ready),
    .rd_valid_o (ibuf_rd_valid),
    .rd_data_o  (ibuf_rd_data),
    .rd_ready_i (dec_ready_i)
  );

  for (genvar i = 0; i < `DECODE_WIDTH; i++) begin : g_dec
    decoder u_decoder (
      .valid_i (ibuf_rd_valid[i]),
      .inst_i  (ibuf_rd_data[i].inst),
      .pc_i    (ibuf_rd_data[i].pc),
      .dec_o   (dec_o[i])
    );
  end

endmodule

//--- testbench/frontend_tb.sv
// Self-checking testbench for the front end pipeline. Models a one-cycle
// instruction memory, drives dec_ready_i and redirects, and checks every
// decoded lane against a reference decoder
`include "frontend_settings.svh"

module frontend_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import frontend_pkg::*;

  localparam int STREAM_LEN    = 64;
  localparam int RANDOM_LEN    = 64;
  localparam int NUM_REDIRECTS = 4;
  localparam int REDIRECT_LEN  = 16;
  localparam int TEST_CYCLES   = 8 + STREAM_LEN + 2 * RANDOM_LEN
                                 + NUM_REDIRECTS * (2 * REDIRECT_LEN + 8);
  localparam int CMP_W         = $bits(decoded_inst_t);

  logic                                clk;
  logic                                rst_i;
  logic                                redirect_i;
  logic [31:0]                         redirect_pc_i;
  imem_req_t                           imem_req_o;
  imem_rsp_t                           imem_rsp_i;
  decoded_inst_t [`DECODE_WIDTH-1:0]   dec_o;
  logic                                dec_ready_i;

  integer        seed = 32'h3b16;
  logic [31:0]   imem [256];
  string         test_name = "reset";
  int            consumed_cnt = 0;
  int            illegal_cnt = 0;
  int            err_cnt = 0;
  int            since_restart = 0;
  logic [31:0]   exp_addr = `RESET_PC;
  logic [`DECODE_WIDTH-1:0] held_valid = '0;
  decoded_inst_t [`DECODE_WIDTH-1:0] held_dec;

  frontend_pipeline u_dut (
    .clk           (clk),
    .rst_i         (rst_i),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .imem_req_o    (imem_req_o),
    .imem_rsp_i    (imem_rsp_i),
    .dec_o         (dec_o),
    .dec_ready_i   (dec_ready_i)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ==========================================================================
  // Reporting and reference model
  // ==========================================================================
  task automatic stop_on_error(input string msg);
    err_cnt++;
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [CMP_W-1:0] expected,
                             input logic [CMP_W-1:0] actual);
    if (actual !== expected) begin
      $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
      stop_on_error("A checked value differs from its expected value");
    end
  endtask

  // Expected decode of one word with its opcode in bits 31:28
  function automatic decoded_inst_t ref_decode(input logic [31:0] word,
                                               input logic [31:0] addr);
    decoded_inst_t d;
    logic [3:0]    code;
    code      = word[31:28];
    d.valid   = 1'b1;
    d.pc      = addr;
    d.illegal = (code > 4'd7);
    d.op      = d.illegal ? OP_NOP : op_e'(code);
    if (code <= 4'd3) begin
      d.unit = UNIT_ALU;
    end else if (code <= 4'd5) begin
      d.unit = UNIT_MEM;
    end else begin
      d.unit = UNIT_MISC;
    end
    d.rd  = word[27:23];
    d.rs0 = word[22:18];
    d.rs1 = word[17:13];
    d.imm = 32'($signed(word[12:0]));
    return d;
  endfunction

  // Instruction memory answering one cycle after each request. Requests
  // must stay low in reset, come one at a time and walk the blocks in order
  initial begin : imem_model
    imem_req_t   req_q;
    imem_rsp_t   rsp_next;
    logic [31:0] fetch_addr;
    logic        req_busy;
    logic        in_reset;
    fetch_addr = `RESET_PC;
    req_busy   = 1'b0;
    in_reset   = 1'b0;
    for (int a = 0; a < 256; a++) begin
      imem[a] = $random(seed);
    end
    imem_rsp_i = '0;
    forever begin
      @(posedge clk);
      req_q    = imem_req_o;
      rsp_next = '0;
      if (in_reset && req_q.valid !== 1'b0) begin
        stop_on_error("Instruction memory request was valid during reset");
      end
      if (req_q.valid === 1'b1) begin
        if (req_busy) begin
          stop_on_error("A second memory request was issued while one was in flight");
        end
        check_value({test_name, " fetch address"}, CMP_W'(fetch_addr),
                    CMP_W'(req_q.addr));
        fetch_addr     = fetch_addr + 32'(`FETCH_WIDTH * 4);
        rsp_next.valid = 1'b1;
        for (int w = 0; w < `FETCH_WIDTH; w++) begin
          rsp_next.data[w] = imem[req_q.addr[9:2] + 8'(w)];
        end
      end
      req_busy = (req_q.valid === 1'b1);
      in_reset = rst_i;
      // Block sequence restarts after reset or a redirect on this edge
      if (rst_i) begin
        fetch_addr = `RESET_PC;
      end else if (redirect_i) begin
        fetch_addr = redirect_pc_i;
      end
      #5;
      imem_rsp_i = rsp_next;
    end
  end

  // ==========================================================================
  // Comparison of the decode lanes
  // ==========================================================================
  always @(posedge clk) begin : compare_lanes
    decoded_inst_t            expected;
    logic [31:0]              lane_addr;
    logic [`DECODE_WIDTH-1:0] lane_valid;
    int                       taken;
    if (rst_i || redirect_i) begin
      // Lanes are flushed on this edge and the stream restarts at the target
      since_restart = 0;
      exp_addr      = rst_i ? `RESET_PC : redirect_pc_i;
      held_valid    = '0;
    end else begin
      if (since_restart < 8) begin
        since_restart++;
      end
      taken = 0;
      for (int i = 0; i < `DECODE_WIDTH; i++) begin
        lane_valid[i] = dec_o[i].valid;
        if (held_valid[i]) begin
          check_value({test_name, " hold"}, held_dec[i], dec_o[i]);
        end
        if (lane_valid[i]) begin
          if (since_restart < 4) begin
            stop_on_error("A decode lane became valid less than 4 cycles after restart");
          end
          lane_addr = exp_addr + 32'(4 * i);
          expected  = ref_decode(imem[lane_addr[9:2]], lane_addr);
          check_value(test_name, expected, dec_o[i]);
          if (dec_ready_i && expected.illegal) begin
            illegal_cnt++;
          end
          taken++;
        end
      end
      // Valid lanes must form a block starting at lane 0
      if ((lane_valid & (lane_valid + `DECODE_WIDTH'(1))) != '0) begin
        stop_on_error("Decode lanes are valid out of program order");
      end
      if (dec_ready_i) begin
        exp_addr     = exp_addr + 32'(4 * taken);
        consumed_cnt = consumed_cnt + taken;
        held_valid   = '0;
      end else begin
        held_valid = lane_valid;
        held_dec   = dec_o;
      end
    end
  end

  // ==========================================================================
  // Stimulus
  // ==========================================================================
  task automatic wait_drive_slot();
    @(posedge clk);
    #5;
  endtask

  // Keep driving dec_ready_i until n more instructions are consumed
  task automatic run_until_consumed(input int n, input bit random_ready);
    int target;
    int rnd;
    target = consumed_cnt + n;
    while (consumed_cnt < target) begin
      wait_drive_slot();
      if (random_ready) begin
        rnd         = $random(seed);
        dec_ready_i = rnd[0];
      end else begin
        dec_ready_i = 1'b1;
      end
    end
  endtask

  initial begin : stimulus
    rst_i         = 1'b1;
    redirect_i    = 1'b0;
    redirect_pc_i = '0;
    dec_ready_i   = 1'b0;
    repeat (3) @(posedge clk);
    #5;
    rst_i = 1'b0;

    test_name = "stream";
    run_until_consumed(STREAM_LEN, 1'b0);

    test_name = "random_ready";
    run_until_consumed(RANDOM_LEN, 1'b1);

    test_name = "redirect";
    for (int r = 0; r < NUM_REDIRECTS; r++) begin
      wait_drive_slot();
      redirect_i    = 1'b1;
      redirect_pc_i = $random(seed) & 32'hffff_fff8;
      wait_drive_slot();
      redirect_i = 1'b0;
      run_until_consumed(REDIRECT_LEN, r[0]);
    end

    if (illegal_cnt == 0) begin
      stop_on_error("No illegal opcode was seen at the decode outputs");
    end
    if (err_cnt == 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      stop_on_error("Errors were recorded during the run");
    end
  end

  // Watchdog
  initial begin
    repeat (TEST_CYCLES * 4) @(posedge clk);
    stop_on_error("Timeout: the decode stream stopped making progress");
  end

endmodule

//--- filelist.f
+incdir+verilog
verilog/frontend_pkg.sv
verilog/fetch_address_queue.sv
verilog/instruction_fetch_unit.sv
verilog/instruction_buffer.sv
verilog/decoder.sv
verilog/frontend_pipeline.sv
testbench/frontend_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the front end testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f filelist.f --top-module frontend_tb -o frontend_sim

status=0
./obj_dir/frontend_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
  echo "Simulation failed, see sim.log"
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi
echo "Simulation passed"
